/* hdl/pipe_settings.svh */
// opcode and stage-count macros for the hazard control
// opcodes are the rv64i major opcodes in bits 6:0 only
// funct fields are never decoded, so all ops in a class look alike
// BACK_STAGES must stay 3 to match the ex/mem/wb stage enum

`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// upper immediate and jumps
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111

// memory access
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011

// register-immediate and register-register alu ops
`define OPC_ITYPE    7'b0010011
`define OPC_ITYPE_W  7'b0011011
`define OPC_RTYPE    7'b0110011
`define OPC_RTYPE_W  7'b0111011

// conditional branches
`define OPC_BRANCH   7'b1100011

// ex, mem and wb
`define BACK_STAGES  3

`endif

/* hdl/rv_pipe_pkg.sv */
// shared types of the pipeline hazard control
// back_t index 0 is always the ex stage, highest index is wb
// register numbers are 5 bits, x0 never counts as a producer

`default_nettype none

`include "pipe_settings.svh"

package rv_pipe_pkg;

    // raw instruction word as offered to id
    typedef logic [31:0] instr_t;

    // names a back stage, order follows back_t index
    typedef enum logic [1:0] {
        ex  = 2'd0,
        mem = 2'd1,
        wb  = 2'd2
    } stage_e;

    // destination record, carried from id down to wb
    typedef struct packed {
        logic       valid;
        // updates some register other than x0
        logic       writes;
        logic       is_load;
        logic [4:0] rd;
    } dest_t;

    // source use of the instruction in id
    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       use_rs1;
        logic       use_rs2;
        // branch, jalr or store, needs operands before ex
        logic       early;
        logic       valid;
    } src_t;

    // forward select for one ex operand
    typedef struct packed {
        logic   en;
        stage_e sel;
    } fwd_t;

    // records of all back stages
    typedef dest_t [`BACK_STAGES-1:0] back_t;

endpackage

`default_nettype wire

/* hdl/id_stage.sv */
// instruction decode register for the hazard control
// only the major opcode is looked at, unknown opcodes read rs1
// holds its contents whenever stall_front is high

`default_nettype none

`include "pipe_settings.svh"

module id_stage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire rv_pipe_pkg::instr_t instr,
    input  wire                   instr_valid,
    input  wire                   stall_front,
    output rv_pipe_pkg::src_t     src,
    output rv_pipe_pkg::dest_t    dest
);

    rv_pipe_pkg::instr_t ir;
    logic                ir_valid;
    logic [6:0]          opc;
    logic [4:0]          rd;

    // valid bit is control state, the word itself is payload
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_valid <= 1'b0;
        end else if (!stall_front) begin
            ir_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_front) begin
            ir <= instr;
        end
    end

    assign opc = ir[6:0];
    assign rd  = ir[11:7];

    always_comb begin
        src.rs1     = ir[19:15];
        src.rs2     = ir[24:20];
        // lui, auipc and jal take pc or immediate only
        src.use_rs1 = !(opc == `OPC_LUI || opc == `OPC_AUIPC || opc == `OPC_JAL);
        // rs2 is a register only for r-type, branch and store
        src.use_rs2 = opc == `OPC_RTYPE || opc == `OPC_RTYPE_W ||
                      opc == `OPC_BRANCH || opc == `OPC_STORE;
        // operands consumed in id, no forward path there
        src.early   = opc == `OPC_BRANCH || opc == `OPC_JALR || opc == `OPC_STORE;
        src.valid   = ir_valid;
    end

    always_comb begin
        dest.valid   = ir_valid;
        // branch and store have no rd, x0 writes are dropped
        dest.writes  = !(opc == `OPC_BRANCH || opc == `OPC_STORE) && (rd != 5'd0);
        dest.is_load = opc == `OPC_LOAD;
        dest.rd      = rd;
    end

endmodule

`default_nettype wire

/* hdl/stage_shift.sv */
// shift of destination records through ex, mem and wb
// one record per stage, index 0 is ex
// hold freezes all stages, bubble only affects what enters ex

`default_nettype none

`include "pipe_settings.svh"

module stage_shift (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire rv_pipe_pkg::dest_t dest_in,
    input  wire                    bubble,
    input  wire                    hold,
    output rv_pipe_pkg::back_t     back
);

    rv_pipe_pkg::back_t back_r;
    rv_pipe_pkg::dest_t ex_in;

    // bubble keeps the payload, only the valid bit drops
    always_comb begin
        ex_in = dest_in;
        if (bubble) begin
            ex_in.valid = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `BACK_STAGES; i++) begin
                back_r[i].valid <= 1'b0;
            end
        end else if (!hold) begin
            back_r[0] <= ex_in;
            // older stages take the record one stage younger
            for (int i = 1; i < `BACK_STAGES; i++) begin
                back_r[i] <= back_r[i-1];
            end
        end
    end

    assign back = back_r;

endmodule

`default_nettype wire

/* hdl/hazard_ctrl.sv */
// stall and forward decision for the instruction in id
// youngest matching back stage wins per source
// a load still in ex or mem, or any match of an early user, stalls
// forward selects are registered and describe the instruction in ex

`default_nettype none

`include "pipe_settings.svh"

module hazard_ctrl (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire rv_pipe_pkg::src_t  src,
    input  wire rv_pipe_pkg::back_t back,
    input  wire                    ext_stall,
    output logic                   stall_front,
    output rv_pipe_pkg::fwd_t      fwd_a,
    output rv_pipe_pkg::fwd_t      fwd_b
);

    // result of the search for one source
    typedef struct packed {
        logic                hit;
        logic                is_load;
        rv_pipe_pkg::stage_e sel;
    } match_t;

    match_t match_a;
    match_t match_b;
    logic   hold_a;
    logic   hold_b;
    logic   hz_stall;

    // walk from wb towards ex so the youngest hit overwrites
    function automatic match_t find_match(
        input logic [4:0]         rs,
        input logic               used,
        input rv_pipe_pkg::back_t recs
    );
        match_t m;
        m = '0;
        for (int i = `BACK_STAGES - 1; i >= 0; i--) begin
            if (used && rs != 5'd0 && recs[i].valid && recs[i].writes &&
                recs[i].rd == rs) begin
                m.hit     = 1'b1;
                m.is_load = recs[i].is_load;
                m.sel     = rv_pipe_pkg::stage_e'(2'(i));
            end
        end
        return m;
    endfunction

    assign match_a = find_match(src.rs1, src.valid && src.use_rs1, back);
    assign match_b = find_match(src.rs2, src.valid && src.use_rs2, back);

    // load data not ready before wb
    // early users cannot take a forward at all
    assign hold_a = match_a.hit &&
                    ((match_a.is_load && match_a.sel != rv_pipe_pkg::wb) || src.early);
    assign hold_b = match_b.hit &&
                    ((match_b.is_load && match_b.sel != rv_pipe_pkg::wb) || src.early);

    assign hz_stall    = hold_a || hold_b;
    assign stall_front = ext_stall || hz_stall;

    // en is control state, sel is payload behind it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fwd_a.en <= 1'b0;
            fwd_b.en <= 1'b0;
        end else if (!ext_stall) begin
            // a bubble enters ex while id is stalled
            fwd_a.en <= match_a.hit && !hz_stall;
            fwd_b.en <= match_b.hit && !hz_stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!ext_stall) begin
            fwd_a.sel <= match_a.sel;
            fwd_b.sel <= match_b.sel;
        end
    end

endmodule

`default_nettype wire

/* hdl/pipe_ctrl_top.sv */
// hazard control top, id stage feeding back-stage shift and controller
// take is the only logic here, valid and not stalled
// fwd_a and fwd_b refer to the instruction currently in ex

`default_nettype none

module pipe_ctrl_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire rv_pipe_pkg::instr_t instr,
    input  wire                     instr_valid,
    input  wire                     ext_stall,
    output wire                     take,
    output wire                     stall_front,
    output wire rv_pipe_pkg::fwd_t  fwd_a,
    output wire rv_pipe_pkg::fwd_t  fwd_b
);

    wire rv_pipe_pkg::src_t  src;
    wire rv_pipe_pkg::dest_t dest;
    wire rv_pipe_pkg::back_t back;

    // offered word enters id at this edge
    assign take = instr_valid && !stall_front;

    id_stage u_id_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall_front (stall_front),
        .src         (src),
        .dest        (dest)
    );

    // stall_front doubles as the ex bubble, ext_stall freezes all
    stage_shift u_stage_shift (
        .clk     (clk),
        .rst_n   (rst_n),
        .dest_in (dest),
        .bubble  (stall_front),
        .hold    (ext_stall),
        .back    (back)
    );

    hazard_ctrl u_hazard_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .src         (src),
        .back        (back),
        .ext_stall   (ext_stall),
        .stall_front (stall_front),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

endmodule

`default_nettype wire

/* sim/pipe_ctrl_checker.sv */
// assertions bound into hazard_ctrl
// fwd sel has no reset, so only the whole struct is checked for stability

`default_nettype none

module pipe_ctrl_checker (
    input wire                    clk,
    input wire                    rst_n,
    input wire                    ext_stall,
    input wire                    stall_front,
    input wire rv_pipe_pkg::fwd_t fwd_a,
    input wire rv_pipe_pkg::fwd_t fwd_b
);

    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench at the end of the run
    int unsigned n_fail = 0;

    // en cleared by a reset edge
    a_fwd_reset: assert property (@(posedge clk) !rst_n |=> !fwd_a.en && !fwd_b.en)
        else begin
            $error("fwd enable set in the cycle after reset");
            n_fail++;
        end

    // a frozen pipeline keeps the ex selects
    a_fwd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ext_stall |=> $stable(fwd_a) && $stable(fwd_b))
        else begin
            $error("fwd outputs changed across an ext_stall cycle");
            n_fail++;
        end

    a_stall_follows_ext: assert property (@(posedge clk) ext_stall |-> stall_front)
        else begin
            $error("stall_front low while ext_stall is high");
            n_fail++;
        end

endmodule

bind hazard_ctrl pipe_ctrl_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .ext_stall   (ext_stall),
    .stall_front (stall_front),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b)
);

`default_nettype wire

/* sim/pipe_ctrl_tb.sv */
// testbench for the hazard control top
// keeps a shadow of id, ex, mem and wb built from driven inputs only
// inputs change on the falling edge, outputs are compared 2 ns later
// fwd sel is only compared while the expected en is set

`default_nettype none

`include "pipe_settings.svh"

module pipe_ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // all offered instructions, sizes the watchdog
    localparam int N_INSTR  = 436;
    localparam int LIMIT_NS = N_INSTR * 4 * 8 + 4000;

    typedef struct packed {
        logic              stall;
        rv_pipe_pkg::fwd_t fa;
        rv_pipe_pkg::fwd_t fb;
    } ref_t;

    logic                clk;
    logic                rst_n;
    rv_pipe_pkg::instr_t instr;
    logic                instr_valid;
    logic                ext_stall;
    logic                take;
    logic                stall_front;
    rv_pipe_pkg::fwd_t   fwd_a;
    rv_pipe_pkg::fwd_t   fwd_b;

    // shadow pipeline
    rv_pipe_pkg::instr_t sh_instr;
    logic                sh_valid;
    rv_pipe_pkg::back_t  sh_back;
    rv_pipe_pkg::fwd_t   sh_fa;
    rv_pipe_pkg::fwd_t   sh_fb;

    string      test_name;
    integer     seed = 27;
    logic [6:0] opcs [11] = '{`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR, `OPC_LOAD,
                              `OPC_STORE, `OPC_ITYPE, `OPC_ITYPE_W, `OPC_RTYPE,
                              `OPC_RTYPE_W, `OPC_BRANCH};

    pipe_ctrl_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .ext_stall   (ext_stall),
        .take        (take),
        .stall_front (stall_front),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // funct bits stay zero, rd field doubles as store/branch imm
    function automatic rv_pipe_pkg::instr_t encode(input logic [6:0] opc,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'd0, rd, opc};
    endfunction

    function automatic rv_pipe_pkg::dest_t dest_of(input rv_pipe_pkg::instr_t w,
            input logic v);
        rv_pipe_pkg::dest_t d;
        d.valid   = v;
        d.writes  = w[6:0] != `OPC_BRANCH && w[6:0] != `OPC_STORE && w[11:7] != 5'd0;
        d.is_load = w[6:0] == `OPC_LOAD;
        d.rd      = w[11:7];
        return d;
    endfunction

    // first hit counting from ex is the youngest producer
    function automatic rv_pipe_pkg::fwd_t youngest(input logic [4:0] rs, input logic used,
            input rv_pipe_pkg::back_t bk);
        rv_pipe_pkg::fwd_t f;
        f = '0;
        for (int s = 0; s < `BACK_STAGES; s++) begin
            if (!f.en && used && rs != 5'd0 && bk[s].valid && bk[s].writes &&
                bk[s].rd == rs) begin
                f.en  = 1'b1;
                f.sel = rv_pipe_pkg::stage_e'(2'(s));
            end
        end
        return f;
    endfunction

    function automatic ref_t pipe_ref(input rv_pipe_pkg::instr_t w, input logic v,
            input rv_pipe_pkg::back_t bk);
        ref_t       r;
        logic [6:0] opc;
        logic       early;
        logic       stall_a;
        logic       stall_b;
        opc   = w[6:0];
        early = opc == `OPC_BRANCH || opc == `OPC_JALR || opc == `OPC_STORE;
        r.fa  = youngest(w[19:15], v && opc != `OPC_LUI && opc != `OPC_AUIPC &&
                         opc != `OPC_JAL, bk);
        r.fb  = youngest(w[24:20], v && (opc == `OPC_RTYPE || opc == `OPC_RTYPE_W ||
                         opc == `OPC_BRANCH || opc == `OPC_STORE), bk);
        // load data exists only from wb on
        stall_a = r.fa.en && (early ||
                  (bk[int'(r.fa.sel)].is_load && r.fa.sel != rv_pipe_pkg::wb));
        stall_b = r.fb.en && (early ||
                  (bk[int'(r.fb.sel)].is_load && r.fb.sel != rv_pipe_pkg::wb));
        r.stall = stall_a || stall_b;
        r.fa.en = r.fa.en && !r.stall;
        r.fb.en = r.fb.en && !r.stall;
        return r;
    endfunction

    task automatic check_stall(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED [%s] %s expected %b actual %b", test_name, name, exp, act);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_fwd(input string name, input rv_pipe_pkg::fwd_t exp,
            input rv_pipe_pkg::fwd_t act);
        if (act.en !== exp.en || (exp.en && act.sel !== exp.sel)) begin
            $display("CHECK FAILED [%s] %s expected en=%b sel=%0d actual en=%b sel=%0d",
                     test_name, name, exp.en, exp.sel, act.en, act.sel);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // shadow moves on the rising edge, same rules as the pipeline
    always @(posedge clk) begin : shadow
        ref_t r;
        logic stall;
        if (!rst_n) begin
            sh_instr = instr;
            sh_valid = 1'b0;
            sh_back  = '0;
            sh_fa    = '0;
            sh_fb    = '0;
        end else begin
            r     = pipe_ref(sh_instr, sh_valid, sh_back);
            stall = ext_stall || r.stall;
            if (!ext_stall) begin
                sh_back[2] = sh_back[1];
                sh_back[1] = sh_back[0];
                sh_back[0] = stall ? rv_pipe_pkg::dest_t'(0) : dest_of(sh_instr, sh_valid);
                sh_fa      = r.fa;
                sh_fb      = r.fb;
            end
            if (!stall) begin
                sh_instr = instr;
                sh_valid = instr_valid;
            end
        end
    end

    initial begin : compare
        ref_t r;
        logic exp_stall;
        wait (rst_n);
        forever begin
            @(negedge clk);
            #2;
            r         = pipe_ref(sh_instr, sh_valid, sh_back);
            exp_stall = ext_stall || r.stall;
            check_stall("stall_front", exp_stall, stall_front);
            check_stall("take", instr_valid && !exp_stall, take);
            check_fwd("fwd_a", sh_fa, fwd_a);
            check_fwd("fwd_b", sh_fb, fwd_b);
        end
    end

    initial begin : watchdog
        #(LIMIT_NS);
        $display("watchdog expired with tests still running");
        $display("test failed");
        $fatal(1, "timeout");
    end

    // freeze for hold cycles first, then offer until taken
    task automatic send(input rv_pipe_pkg::instr_t w, input int hold);
        logic took;
        took = 1'b0;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            instr       = w;
            instr_valid = 1'b1;
            ext_stall   = 1'b1;
        end
        while (!took) begin
            @(negedge clk);
            instr       = w;
            instr_valid = 1'b1;
            ext_stall   = 1'b0;
            #2;
            took = take;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
            ext_stall   = 1'b0;
        end
    endtask

    initial begin : stimulus
        rv_pipe_pkg::instr_t w;
        int                  hold;
        instr       = '0;
        instr_valid = 1'b0;
        ext_stall   = 1'b0;
        rst_n       = 1'b0;
        test_name   = "reset";
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        // ex, then mem and wb, youngest of several wins
        test_name = "alu_fwd";
        send(encode(`OPC_RTYPE, 1, 2, 3), 0);
        send(encode(`OPC_RTYPE, 1, 1, 2), 0);
        send(encode(`OPC_RTYPE, 2, 1, 1), 0);
        send(encode(`OPC_ITYPE, 3, 0, 0), 0);
        send(encode(`OPC_ITYPE, 0, 0, 0), 0);
        send(encode(`OPC_RTYPE, 4, 3, 0), 0);
        send(encode(`OPC_ITYPE, 5, 0, 0), 0);
        send(encode(`OPC_ITYPE, 0, 0, 0), 0);
        send(encode(`OPC_ITYPE, 0, 0, 0), 0);
        send(encode(`OPC_RTYPE, 6, 5, 5), 0);
        idle(4);

        test_name = "load_use";
        send(encode(`OPC_LOAD, 7, 1, 0), 0);
        send(encode(`OPC_RTYPE, 8, 7, 0), 0);
        send(encode(`OPC_LOAD, 7, 1, 0), 0);
        send(encode(`OPC_ITYPE, 0, 0, 0), 0);
        send(encode(`OPC_RTYPE, 9, 0, 7), 0);
        idle(4);

        // x0 writes, store and branch imm, unused rs fields
        test_name = "no_false_dep";
        send(encode(`OPC_RTYPE, 0, 1, 2), 0);
        send(encode(`OPC_RTYPE, 3, 0, 0), 0);
        send(encode(`OPC_STORE, 5, 1, 2), 0);
        send(encode(`OPC_RTYPE, 6, 5, 5), 0);
        send(encode(`OPC_BRANCH, 7, 0, 0), 0);
        send(encode(`OPC_RTYPE, 8, 7, 7), 0);
        send(encode(`OPC_ITYPE, 9, 0, 0), 0);
        send(encode(`OPC_ITYPE, 10, 0, 9), 0);
        send(encode(`OPC_LUI, 11, 9, 9), 0);
        idle(4);

        test_name = "early_use";
        send(encode(`OPC_RTYPE, 12, 0, 0), 0);
        send(encode(`OPC_BRANCH, 0, 12, 0), 0);
        send(encode(`OPC_RTYPE, 13, 0, 0), 0);
        send(encode(`OPC_JALR, 1, 13, 0), 0);
        send(encode(`OPC_RTYPE, 14, 0, 0), 0);
        send(encode(`OPC_STORE, 0, 0, 14), 0);
        idle(4);

        // freeze with fwd active and inside a load-use stall
        test_name = "ext_stall";
        send(encode(`OPC_RTYPE, 15, 0, 0), 0);
        send(encode(`OPC_RTYPE, 16, 15, 15), 3);
        send(encode(`OPC_ITYPE, 17, 16, 0), 2);
        send(encode(`OPC_LOAD, 18, 0, 0), 2);
        send(encode(`OPC_RTYPE, 19, 18, 0), 0);
        send(encode(`OPC_ITYPE, 20, 19, 0), 2);
        idle(4);

        test_name = "random";
        for (int n = 0; n < 400; n++) begin
            w    = encode(opcs[$unsigned($random(seed)) % 11],
                          5'($unsigned($random(seed)) % 4),
                          5'($unsigned($random(seed)) % 4),
                          5'($unsigned($random(seed)) % 4));
            hold = (($random(seed) & 7) == 0) ? 1 + $unsigned($random(seed)) % 2 : 0;
            send(w, hold);
        end
        idle(6);

        if (dut.u_hazard_ctrl.u_checker.n_fail != 0) begin
            $display("bound checker saw %0d assertion failures",
                     dut.u_hazard_ctrl.u_checker.n_fail);
            $display("test failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/rv_pipe_pkg.sv
hdl/id_stage.sv
hdl/stage_shift.sv
hdl/hazard_ctrl.sv
hdl/pipe_ctrl_top.sv
sim/pipe_ctrl_checker.sv
sim/pipe_ctrl_tb.sv

/* Makefile */
# Verilator build and run of the hazard control testbench
# pass or fail is taken from the simulation log

VERILATOR ?= verilator
TOP       ?= pipe_ctrl_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
